// File: lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// ----------------------------------------
// datapath
// ----------------------------------------
`define LSU_XLEN 32 // data and address width

// ----------------------------------------
// address map
// ----------------------------------------
`define LSU_DMEM_LIMIT 32'h0000_0800 // first byte past the 2 KB data memory
`define LSU_PERIPH_BASE 32'h1000_0000 // output buffer start
`define LSU_PERIPH_LIMIT 32'h1000_5000 // output buffer end, exclusive
`define LSU_SW_PAGE 20'h10010 // addr[31:12] of the switch register

// ----------------------------------------
// storage and peripheral sizes
// ----------------------------------------
`define LSU_DMEM_WORDS 512 // data memory depth in words

// each seven-segment digit is active in bits 6:0 of its byte
`define LSU_HEX_W 7

`endif

// File: lsu_ctrl.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_ctrl (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_req,
  input  lsu_pkg::lsu_op_e       i_op,
  input  logic [`LSU_XLEN-1:0]   i_addr,
  input  logic [`LSU_XLEN-1:0]   i_sw,
  input  logic [`LSU_XLEN-1:0]   i_dmem_rdata,
  input  logic [`LSU_XLEN-1:0]   i_periph_rdata,
  output logic                   o_ack,
  output logic [`LSU_XLEN-1:0]   o_ld_data,
  output logic                   o_dmem_we,
  output logic                   o_periph_we
);

  import lsu_pkg::*;

  lsu_hs_e              hs_q;
  lsu_hs_e              hs_d;
  lsu_region_e          region;
  logic                 accept;
  logic                 is_store;
  logic [`LSU_XLEN-1:0] sw_q;
  logic [`LSU_XLEN-1:0] ld_sel;

  // ----------------------------------------
  // region decode
  // ----------------------------------------
  always_comb begin
    if (i_addr < `LSU_DMEM_LIMIT) begin
      region = REG_DMEM;
    end else if ((i_addr >= `LSU_PERIPH_BASE) && (i_addr < `LSU_PERIPH_LIMIT)) begin
      region = REG_PERIPH;
    end else if (i_addr[31:12] == `LSU_SW_PAGE) begin
      region = REG_SWITCH;
    end else begin
      region = REG_NONE; // loads zero, stores dropped
    end
  end

  // ----------------------------------------
  // req/ack handshake
  // ----------------------------------------
  assign accept = i_req && (hs_q == HS_IDLE); // the one cycle an access completes

  always_comb begin
    hs_d = hs_q;
    case (hs_q)
      HS_IDLE: if (i_req) hs_d = HS_ACK;
      HS_ACK:  if (!i_req) hs_d = HS_IDLE; // master released req
      default: hs_d = HS_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      hs_q <= HS_IDLE;
    end else begin
      hs_q <= hs_d;
    end
  end

  assign o_ack = (hs_q == HS_ACK);

  // ----------------------------------------
  // store strobes
  // ----------------------------------------
  assign is_store    = (i_op == SB) || (i_op == SH) || (i_op == SW);
  assign o_dmem_we   = accept && is_store && (region == REG_DMEM);
  assign o_periph_we = accept && is_store && (region == REG_PERIPH);

  // switch input, one cycle behind the pins
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      sw_q <= '0;
    end else begin
      sw_q <= i_sw;
    end
  end

  // ----------------------------------------
  // load select and result register
  // ----------------------------------------
  always_comb begin
    case (region)
      REG_DMEM:   ld_sel = i_dmem_rdata;   // already lane-extended
      REG_PERIPH: ld_sel = i_periph_rdata;
      REG_SWITCH: ld_sel = sw_q;           // raw word, no lanes
      default:    ld_sel = '0;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      o_ld_data <= '0;
    end else if (accept && !is_store) begin
      o_ld_data <= ld_sel; // held through stores and idle cycles
    end
  end

endmodule

// File: lsu_dmem.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_dmem #(
  parameter int DEPTH = `LSU_DMEM_WORDS
) (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_we,
  input  lsu_pkg::lsu_op_e       i_op,
  input  logic [`LSU_XLEN-1:0]   i_addr,
  input  logic [`LSU_XLEN-1:0]   i_st_data,
  output logic [`LSU_XLEN-1:0]   o_rdata
);

  import lsu_pkg::*;

  localparam int AW = $clog2(DEPTH); // word index width

  logic [`LSU_XLEN-1:0] mem [0:DEPTH-1];
  logic [AW-1:0]        word_idx;
  logic [`LSU_XLEN-1:0] st_word;

  assign word_idx = i_addr[AW+1:2]; // byte address to word index

  lsu_lane u_lane (
    .i_op      (i_op),
    .i_offset  (i_addr[1:0]),
    .i_st_data (i_st_data),
    .i_word    (mem[word_idx]), // asynchronous read
    .o_st_word (st_word),
    .o_ld_word (o_rdata)
  );

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (i_we) begin
      mem[word_idx] <= st_word; // read-modify-write of the lane
    end
  end

endmodule

// File: lsu_lane.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_lane (
  input  lsu_pkg::lsu_op_e       i_op,
  input  logic [1:0]             i_offset,
  input  logic [`LSU_XLEN-1:0]   i_st_data,
  input  logic [`LSU_XLEN-1:0]   i_word,
  output logic [`LSU_XLEN-1:0]   o_st_word,
  output logic [`LSU_XLEN-1:0]   o_ld_word
);

  import lsu_pkg::*;

  logic [4:0]  byte_base; // bit position of the addressed byte
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  assign byte_base = {i_offset, 3'b000};
  assign ld_byte   = i_word[byte_base +: 8];
  assign ld_half   = i_offset[1] ? i_word[31:16] : i_word[15:0];

  // ----------------------------------------
  // store merge
  // ----------------------------------------
  always_comb begin
    o_st_word = i_word; // untouched lanes keep the old word
    case (i_op)
      SB: begin
        o_st_word[byte_base +: 8] = i_st_data[7:0];
      end
      SH: begin
        if (i_offset[1]) begin
          o_st_word[31:16] = i_st_data[15:0];
        end else begin
          o_st_word[15:0] = i_st_data[15:0];
        end
      end
      SW: begin
        o_st_word = i_st_data; // offset ignored
      end
      default: begin
        o_st_word = i_word; // loads leave the word alone
      end
    endcase
  end

  // ----------------------------------------
  // load extract and extend
  // ----------------------------------------
  always_comb begin
    case (i_op)
      LB: begin
        o_ld_word = {{24{ld_byte[7]}}, ld_byte};
      end
      LBU: begin
        o_ld_word = {24'h0, ld_byte}; // plain zero extension for every lane
      end
      LH: begin
        o_ld_word = {{16{ld_half[15]}}, ld_half};
      end
      LHU: begin
        o_ld_word = {16'h0, ld_half};
      end
      default: begin
        o_ld_word = i_word; // LW, and don't care for stores
      end
    endcase
  end

endmodule

// File: lsu_periph.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_periph (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_we,
  input  lsu_pkg::lsu_op_e       i_op,
  input  logic [`LSU_XLEN-1:0]   i_addr,
  input  logic [`LSU_XLEN-1:0]   i_st_data,
  output logic [`LSU_XLEN-1:0]   o_rdata,
  output logic [`LSU_XLEN-1:0]   o_ledr,
  output logic [`LSU_XLEN-1:0]   o_ledg,
  output logic [`LSU_HEX_W-1:0]  o_hex0,
  output logic [`LSU_HEX_W-1:0]  o_hex1,
  output logic [`LSU_HEX_W-1:0]  o_hex2,
  output logic [`LSU_HEX_W-1:0]  o_hex3,
  output logic [`LSU_HEX_W-1:0]  o_hex4,
  output logic [`LSU_HEX_W-1:0]  o_hex5,
  output logic [`LSU_HEX_W-1:0]  o_hex6,
  output logic [`LSU_HEX_W-1:0]  o_hex7,
  output logic [`LSU_XLEN-1:0]   o_lcd
);

  import lsu_pkg::*;
  import periph_pkg::*;

  logic [`LSU_XLEN-1:0] regs [0:4];
  periph_sel_e          sel;
  logic                 sel_ok;
  logic [`LSU_XLEN-1:0] cur_word;
  logic [`LSU_XLEN-1:0] st_word;

  // ----------------------------------------
  // register select
  // ----------------------------------------
  assign sel    = periph_sel_e'(i_addr[14:12]);
  assign sel_ok = !i_addr[15] && (i_addr[14:12] <= P_LCD); // pages 5..15 unused

  always_comb begin
    cur_word = '0;
    if (sel_ok) begin
      case (sel)
        P_LEDR:  cur_word = regs[P_LEDR];
        P_LEDG:  cur_word = regs[P_LEDG];
        P_HEX30: cur_word = regs[P_HEX30];
        P_HEX74: cur_word = regs[P_HEX74];
        P_LCD:   cur_word = regs[P_LCD];
        default: cur_word = '0;
      endcase
    end
  end

  lsu_lane u_lane (
    .i_op      (i_op),
    .i_offset  (i_addr[1:0]),
    .i_st_data (i_st_data),
    .i_word    (cur_word),
    .o_st_word (st_word),
    .o_ld_word (o_rdata)
  );

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      for (int i = 0; i < 5; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && sel_ok) begin
      regs[sel] <= st_word;
    end
  end

  // ----------------------------------------
  // fan-out to the board
  // ----------------------------------------
  assign o_ledr = regs[P_LEDR];
  assign o_ledg = regs[P_LEDG];
  assign o_lcd  = regs[P_LCD];

  assign o_hex0 = regs[P_HEX30][`LSU_HEX_W-1:0];
  assign o_hex1 = regs[P_HEX30][8 +: `LSU_HEX_W];
  assign o_hex2 = regs[P_HEX30][16 +: `LSU_HEX_W];
  assign o_hex3 = regs[P_HEX30][24 +: `LSU_HEX_W];
  assign o_hex4 = regs[P_HEX74][`LSU_HEX_W-1:0];
  assign o_hex5 = regs[P_HEX74][8 +: `LSU_HEX_W];
  assign o_hex6 = regs[P_HEX74][16 +: `LSU_HEX_W];
  assign o_hex7 = regs[P_HEX74][24 +: `LSU_HEX_W];

endmodule

// File: lsu_pkg.sv
package lsu_pkg;

  // ----------------------------------------
  // load/store opcode, same codes as the core
  // ----------------------------------------
  typedef enum logic [2:0] {
    SB  = 3'd0,
    SH  = 3'd1,
    SW  = 3'd2,
    LB  = 3'd3,
    LH  = 3'd4,
    LW  = 3'd5,
    LBU = 3'd6,
    LHU = 3'd7
  } lsu_op_e;

  // decoded target of an access
  typedef enum logic [1:0] {
    REG_DMEM,   // on-chip data memory
    REG_PERIPH, // output buffer
    REG_SWITCH, // switch input register
    REG_NONE    // unmapped, loads zero
  } lsu_region_e;

  // req/ack handshake
  typedef enum logic {
    HS_IDLE, // waiting for a request
    HS_ACK   // ack high until req drops
  } lsu_hs_e;

endpackage

// File: lsu_tests.txt
# S sw | T op addr st_data chk expect (chk 0: store, no compare) | H addr add hold_cycles
# P index expect: 0 LEDR, 1 LEDG, 2 LCD, 3..10 HEX0..HEX7; ops SB0 SH1 SW2 LB3 LH4 LW5 LBU6 LHU7
T 5 00000010 00000000 1 00000000
T 2 00000000 12345678 0 0
T 2 00000100 cafef00d 0 0
T 2 000007f8 8badf00d 0 0
T 5 00000000 00000000 1 12345678
T 5 00000100 00000000 1 cafef00d
T 5 000007f8 00000000 1 8badf00d
# byte and halfword stores merge into a prior word
T 2 00000200 11223344 0 0
T 0 00000200 000000aa 0 0
T 0 00000201 000000bb 0 0
T 0 00000202 000000cc 0 0
T 0 00000203 000000dd 0 0
T 5 00000200 00000000 1 ddccbbaa
T 2 00000204 11223344 0 0
T 1 00000204 0000beef 0 0
T 1 00000206 ffff5a5a 0 0
T 5 00000204 00000000 1 5a5abeef
# narrow loads from 9a7fe581
T 2 00000208 9a7fe581 0 0
T 3 00000208 00000000 1 ffffff81
T 3 0000020a 00000000 1 0000007f
T 3 0000020b 00000000 1 ffffff9a
T 6 00000209 00000000 1 000000e5
T 6 0000020b 00000000 1 0000009a
T 4 00000208 00000000 1 ffffe581
T 4 0000020a 00000000 1 ffff9a7f
T 7 00000208 00000000 1 0000e581
T 7 0000020a 00000000 1 00009a7f
# output registers
T 2 10000000 a5a5a5a5 0 0
T 2 10001000 0000ffff 0 0
T 2 10004000 4c434420 0 0
T 2 10002000 7f402a81 0 0
T 2 10003000 12345678 0 0
P 0 a5a5a5a5
P 1 0000ffff
P 2 4c434420
P 3 00000001
P 4 0000002a
P 6 0000007f
P 7 00000078
P a 00000012
T 0 10002001 00000063 0 0
P 3 00000001
P 4 00000063
P 5 00000040
T 5 10002000 00000000 1 7f406381
T 5 10004000 00000000 1 4c434420
T 6 10003002 00000000 1 00000034
# switch page and unmapped addresses
S 13579bdf
T 5 10010000 00000000 1 13579bdf
T 3 10010001 00000000 1 13579bdf
T 2 20000000 ffffffff 0 0
T 2 10005000 ffffffff 0 0
P 0 a5a5a5a5
P 2 4c434420
P 6 0000007f
T 5 20000000 00000000 1 00000000
T 5 00000800 00000000 1 00000000
# handshake with req held past ack
H 000007fe 37 3
H 000007fe 58 2

// File: lsu_top.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module lsu_top (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_req,
  input  lsu_pkg::lsu_op_e       i_op,
  input  logic [`LSU_XLEN-1:0]   i_addr,
  input  logic [`LSU_XLEN-1:0]   i_st_data,
  input  logic [`LSU_XLEN-1:0]   i_sw,
  output logic                   o_ack,
  output logic [`LSU_XLEN-1:0]   o_ld_data,
  output logic [`LSU_XLEN-1:0]   o_ledr,
  output logic [`LSU_XLEN-1:0]   o_ledg,
  output logic [`LSU_HEX_W-1:0]  o_hex0,
  output logic [`LSU_HEX_W-1:0]  o_hex1,
  output logic [`LSU_HEX_W-1:0]  o_hex2,
  output logic [`LSU_HEX_W-1:0]  o_hex3,
  output logic [`LSU_HEX_W-1:0]  o_hex4,
  output logic [`LSU_HEX_W-1:0]  o_hex5,
  output logic [`LSU_HEX_W-1:0]  o_hex6,
  output logic [`LSU_HEX_W-1:0]  o_hex7,
  output logic [`LSU_XLEN-1:0]   o_lcd
);

  import lsu_pkg::*;

  logic                 dmem_we;
  logic                 periph_we;
  logic [`LSU_XLEN-1:0] dmem_rdata;
  logic [`LSU_XLEN-1:0] periph_rdata;

  // ----------------------------------------
  // handshake, decode, load select
  // ----------------------------------------
  lsu_ctrl u_ctrl (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_req          (i_req),
    .i_op           (i_op),
    .i_addr         (i_addr),
    .i_sw           (i_sw),
    .i_dmem_rdata   (dmem_rdata),
    .i_periph_rdata (periph_rdata),
    .o_ack          (o_ack),
    .o_ld_data      (o_ld_data),
    .o_dmem_we      (dmem_we),
    .o_periph_we    (periph_we)
  );

  // ----------------------------------------
  // storage
  // ----------------------------------------
  lsu_dmem u_dmem (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_we      (dmem_we),
    .i_op      (i_op),
    .i_addr    (i_addr),
    .i_st_data (i_st_data),
    .o_rdata   (dmem_rdata)
  );

  lsu_periph u_periph (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_we      (periph_we),
    .i_op      (i_op),
    .i_addr    (i_addr),
    .i_st_data (i_st_data),
    .o_rdata   (periph_rdata),
    .o_ledr    (o_ledr),
    .o_ledg    (o_ledg),
    .o_hex0    (o_hex0),
    .o_hex1    (o_hex1),
    .o_hex2    (o_hex2),
    .o_hex3    (o_hex3),
    .o_hex4    (o_hex4),
    .o_hex5    (o_hex5),
    .o_hex6    (o_hex6),
    .o_hex7    (o_hex7),
    .o_lcd     (o_lcd)
  );

endmodule

// File: periph_pkg.sv
package periph_pkg;

  // ----------------------------------------
  // output buffer register select
  // ----------------------------------------
  // taken from addr[14:12]; addr[15:12] above 4 selects nothing
  typedef enum logic [2:0] {
    P_LEDR  = 3'd0, // red LEDs
    P_LEDG  = 3'd1, // green LEDs
    P_HEX30 = 3'd2, // HEX digits 0-3
    P_HEX74 = 3'd3, // HEX digits 4-7
    P_LCD   = 3'd4  // LCD word
  } periph_sel_e;

endpackage

// File: project.f
+incdir+.
lsu_pkg.sv
periph_pkg.sv
lsu_lane.sv
lsu_dmem.sv
lsu_periph.sv
lsu_ctrl.sv
lsu_top.sv
tb_clkgen.sv
tb_lsu.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_lsu -f project.f
sim_out=$(./obj_dir/Vtb_lsu)
echo "$sim_out"

if grep -qF "All tests passed!" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

// File: tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
  parameter int HALF_PERIOD  = 10, // 20 ns clock
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_reset <= 1'b0; // released on a rising edge
  end

endmodule

// File: tb_lsu.sv
`timescale 1ns/100ps
`include "lsu_cfg.svh"

module tb_lsu;

  import lsu_pkg::*;

  logic                  i_clk;
  logic                  i_reset;
  logic                  i_req;
  lsu_op_e               i_op;
  logic [`LSU_XLEN-1:0]  i_addr;
  logic [`LSU_XLEN-1:0]  i_st_data;
  logic [`LSU_XLEN-1:0]  i_sw;
  logic                  o_ack;
  logic [`LSU_XLEN-1:0]  o_ld_data;
  logic [`LSU_XLEN-1:0]  o_ledr;
  logic [`LSU_XLEN-1:0]  o_ledg;
  logic [`LSU_XLEN-1:0]  o_lcd;
  logic [`LSU_HEX_W-1:0] o_hex [0:7];

  int        cycle_cnt = 0;
  int        cycle_limit = 0;
  int        test_num = 0;
  int        pass_cnt = 0;
  int        fail_cnt = 0;
  bit        test_bad = 1'b0;
  logic [7:0] tracked_byte = 8'h00; // byte under the handshake check

  tb_clkgen u_clkgen (
    .o_clk   (i_clk),
    .o_reset (i_reset)
  );

  lsu_top i_lsu_top (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_req     (i_req),
    .i_op      (i_op),
    .i_addr    (i_addr),
    .i_st_data (i_st_data),
    .i_sw      (i_sw),
    .o_ack     (o_ack),
    .o_ld_data (o_ld_data),
    .o_ledr    (o_ledr),
    .o_ledg    (o_ledg),
    .o_hex0    (o_hex[0]),
    .o_hex1    (o_hex[1]),
    .o_hex2    (o_hex[2]),
    .o_hex3    (o_hex[3]),
    .o_hex4    (o_hex[4]),
    .o_hex5    (o_hex[5]),
    .o_hex6    (o_hex[6]),
    .o_hex7    (o_hex[7]),
    .o_lcd     (o_lcd)
  );

  // watchdog limit is set once the tests file is counted
  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s read %08h, expected %08h", $time, what, got, exp);
      test_bad = 1'b1;
    end
  endtask

  task automatic close_test(input string desc);
    test_num++;
    if (test_bad) fail_cnt++;
    else pass_cnt++;
    $display("test %0d %s: %s", test_num, desc, test_bad ? "mismatch" : "ok");
    test_bad = 1'b0;
  endtask

  function automatic logic [31:0] port_value(input int idx);
    case (idx)
      0: return o_ledr;
      1: return o_ledg;
      2: return o_lcd;
      default: return (idx <= 10) ? {25'h0, o_hex[idx-3]} : 32'hdead_beef;
    endcase
  endfunction

  // four digits starting at first show bits 6:0 of each byte of word
  task automatic check_digits(input int first, input logic [31:0] word);
    for (int d = 0; d < 4; d++) begin
      check_value($sformatf("HEX%0d", first + d), {25'h0, o_hex[first + d]},
                  {25'h0, word[8*d +: `LSU_HEX_W]});
    end
  endtask

  // one four-phase transfer with req held for hold extra cycles after ack
  task automatic run_access(input logic [2:0] op, input logic [31:0] addr,
                            input logic [31:0] data, input int hold);
    @(posedge i_clk);
    i_req     <= 1'b1;
    i_op      <= lsu_op_e'(op);
    i_addr    <= addr;
    i_st_data <= data;
    @(negedge i_clk);
    while (!o_ack) @(negedge i_clk);
    for (int k = 0; k < hold; k++) begin
      @(posedge i_clk);
      i_st_data <= ~data; // a second write would store this
      @(negedge i_clk);
      check_value("ack while req held", {31'h0, o_ack}, 32'h1);
    end
    @(posedge i_clk);
    i_req <= 1'b0;
    @(negedge i_clk);
    while (o_ack) @(negedge i_clk); // ack falls after req seen low
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    int          fd;
    int          n;
    int          n_cmds;
    string       line;
    byte         cmd;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;

    i_req     = 1'b0;
    i_op      = LW;
    i_addr    = '0;
    i_st_data = '0;
    i_sw      = '0;
    n_cmds    = 0;
    f0 = '0;
    f1 = '0;
    f2 = '0;
    f3 = '0;
    f4 = '0;

    fd = $fopen("lsu_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open lsu_tests.txt");
      fail_cnt++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") n_cmds++;
      end
      $fclose(fd);
      cycle_limit = 20 * n_cmds + 100;

      wait (!i_reset);
      @(negedge i_clk);
      check_value("ack after reset", {31'h0, o_ack}, 32'h0);
      close_test("ack low after reset");

      fd = $fopen("lsu_tests.txt", "r");
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          cmd = line.getc(0);
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                      f0, f1, f2, f3, f4);
          case (cmd)
            "S": begin
              @(posedge i_clk);
              i_sw <= f0;
              repeat (2) @(posedge i_clk); // switch register lags one cycle
              close_test($sformatf("S sw=%08h", f0));
            end
            "T": begin
              run_access(f0[2:0], f1, f2, 0);
              if (f3[0]) begin
                check_value($sformatf("load op %0d at %08h", f0[2:0], f1), o_ld_data, f4);
              end
              // a word store to a HEX register sets all four of its digits
              if (f0[2:0] == 3'd2 && f1[31:12] == 20'h10002) begin
                check_digits(0, f2);
              end
              if (f0[2:0] == 3'd2 && f1[31:12] == 20'h10003) begin
                check_digits(4, f2);
              end
              close_test($sformatf("T op=%0d addr=%08h", f0[2:0], f1));
            end
            "P": begin
              @(negedge i_clk);
              check_value($sformatf("output %0d", f0), port_value(f0), f1);
              close_test($sformatf("P output %0d", f0));
            end
            "H": begin
              tracked_byte = tracked_byte + f1[7:0];
              run_access(3'd0, f0, {24'h0, tracked_byte}, f2); // SB with req held
              run_access(3'd6, f0, 32'h0, 0);                  // LBU read back
              check_value($sformatf("byte at %08h", f0), o_ld_data, {24'h0, tracked_byte});
              close_test($sformatf("H addr=%08h hold=%0d", f0, f2));
            end
            default: begin
              $display("unknown command '%c' in lsu_tests.txt", cmd);
              test_bad = 1'b1;
              close_test("bad line");
            end
          endcase
        end
      end
      $fclose(fd);
    end

    $display("tests: %0d, passed: %0d, failed: %0d", test_num, pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
